//--- mips_fde.f
+incdir+source
source/mips_pkg.sv
source/insn_memory.sv
source/fetch_stage.sv
source/register_file.sv
source/decode_stage.sv
source/alu_stage.sv
source/mips_core.sv
verif/mips_core_assert.sv
verif/mips_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module mips_core_tb \
	-f mips_fde.f

./obj_dir/Vmips_core_tb | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

//--- source/alu_stage.sv
`timescale 1ns/100ps

module alu_stage (
	input  logic clock,
	input  logic reset,
	input  logic stall,
	input  mips_pkg::decode_t decoded,
	output logic wb_write,
	output mips_pkg::reg_index_t wb_dest,
	output mips_pkg::word_t wb_value,
	output logic result_valid,
	output mips_pkg::exec_result_t result,
	output logic done
);

	mips_pkg::word_t alu_value;
	mips_pkg::word_t op_a;
	mips_pkg::word_t op_b;
	logic valid_q;
	logic last_q;

	assign op_a = decoded.operand_a;
	assign op_b = decoded.operand_b;

	always_comb begin
		case (decoded.alu_op)
			mips_pkg::ALU_ADD: alu_value = op_a + op_b;
			mips_pkg::ALU_SUB: alu_value = op_a - op_b;
			mips_pkg::ALU_AND: alu_value = op_a & op_b;
			mips_pkg::ALU_OR: alu_value = op_a | op_b;
			mips_pkg::ALU_XOR: alu_value = op_a ^ op_b;
			mips_pkg::ALU_NOR: alu_value = ~(op_a | op_b);
			mips_pkg::ALU_SLT: alu_value = {31'd0, $signed(op_a) < $signed(op_b)};
			mips_pkg::ALU_SLTU: alu_value = {31'd0, op_a < op_b};
			mips_pkg::ALU_SLL: alu_value = op_b << decoded.shamt;
			mips_pkg::ALU_SRL: alu_value = op_b >> decoded.shamt;
			mips_pkg::ALU_SRA: alu_value = $signed(op_b) >>> decoded.shamt;
			mips_pkg::ALU_LUI: alu_value = {op_b[15:0], 16'h0000};
			default: alu_value = '0;
		endcase
	end

	// Writeback lands on the same edge as the result register
	assign wb_write = decoded.valid && decoded.write && !stall;
	assign wb_dest = decoded.dest;
	assign wb_value = alu_value;

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
			last_q <= 1'b0;
		end else if (!stall) begin
			valid_q <= decoded.valid;
			last_q <= decoded.valid && decoded.last;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			result <= '{
				pc: decoded.pc,
				dest: decoded.dest,
				write: decoded.write,
				value: alu_value
			};
		end
	end

	// Held item is reported once on its first unstalled cycle
	assign result_valid = valid_q && !stall;

	always_ff @(posedge clock) begin
		if (reset) begin
			done <= 1'b0;
		end else if (!stall) begin
			if (valid_q && last_q)
				done <= 1'b1;
			else if (decoded.valid)
				done <= 1'b0; // new program on its way
		end
	end

endmodule

//--- source/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
	input  logic clock,
	input  logic reset,
	input  logic stall,
	input  mips_pkg::fetch_t fetched,
	input  mips_pkg::word_t insn,
	input  mips_pkg::word_t rs_value,
	input  mips_pkg::word_t rt_value,
	output mips_pkg::reg_index_t rs_index,
	output mips_pkg::reg_index_t rt_index,
	output mips_pkg::decode_t decoded
);

	mips_pkg::opcode_e opcode;
	mips_pkg::funct_e funct;
	mips_pkg::reg_index_t rd_index;
	logic [4:0] shamt_field;
	logic [15:0] imm_field;
	mips_pkg::word_t imm_ext;
	mips_pkg::alu_op_e alu_op;
	logic is_rtype;
	logic var_shift;
	logic zero_ext;
	mips_pkg::decode_t decode_next;

	// Instruction fields
	assign opcode = mips_pkg::opcode_e'(insn[31:26]);
	assign rs_index = insn[25:21];
	assign rt_index = insn[20:16];
	assign rd_index = insn[15:11];
	assign shamt_field = insn[10:6];
	assign funct = mips_pkg::funct_e'(insn[5:0]);
	assign imm_field = insn[15:0];

	assign is_rtype = opcode == mips_pkg::OP_RTYPE;
	assign zero_ext = (opcode == mips_pkg::OP_ORI) || (opcode == mips_pkg::OP_XORI);
	assign imm_ext = zero_ext ? {16'h0000, imm_field} : {{16{imm_field[15]}}, imm_field};

	always_comb begin
		alu_op = mips_pkg::ALU_NONE;
		var_shift = 1'b0;
		case (opcode)
			mips_pkg::OP_RTYPE: begin
				case (funct)
					mips_pkg::F_ADD, mips_pkg::F_ADDU: alu_op = mips_pkg::ALU_ADD; // no trap
					mips_pkg::F_SUB, mips_pkg::F_SUBU: alu_op = mips_pkg::ALU_SUB;
					mips_pkg::F_AND: alu_op = mips_pkg::ALU_AND;
					mips_pkg::F_OR: alu_op = mips_pkg::ALU_OR;
					mips_pkg::F_XOR: alu_op = mips_pkg::ALU_XOR;
					mips_pkg::F_NOR: alu_op = mips_pkg::ALU_NOR;
					mips_pkg::F_SLT: alu_op = mips_pkg::ALU_SLT;
					mips_pkg::F_SLTU: alu_op = mips_pkg::ALU_SLTU;
					mips_pkg::F_SLL: alu_op = mips_pkg::ALU_SLL;
					mips_pkg::F_SRL: alu_op = mips_pkg::ALU_SRL;
					mips_pkg::F_SRA: alu_op = mips_pkg::ALU_SRA;
					mips_pkg::F_SLLV: begin
						alu_op = mips_pkg::ALU_SLL;
						var_shift = 1'b1;
					end
					mips_pkg::F_SRLV: begin
						alu_op = mips_pkg::ALU_SRL;
						var_shift = 1'b1;
					end
					mips_pkg::F_SRAV: begin
						alu_op = mips_pkg::ALU_SRA;
						var_shift = 1'b1;
					end
					default: alu_op = mips_pkg::ALU_NONE;
				endcase
			end
			mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU: alu_op = mips_pkg::ALU_ADD;
			mips_pkg::OP_SLTI: alu_op = mips_pkg::ALU_SLT;
			mips_pkg::OP_SLTIU: alu_op = mips_pkg::ALU_SLTU; // unsigned compare on sign-extended imm
			mips_pkg::OP_ORI: alu_op = mips_pkg::ALU_OR;
			mips_pkg::OP_XORI: alu_op = mips_pkg::ALU_XOR;
			mips_pkg::OP_LUI: alu_op = mips_pkg::ALU_LUI;
			default: alu_op = mips_pkg::ALU_NONE; // dropped ops retire as no-op
		endcase
	end

	always_comb begin
		decode_next.valid = fetched.valid;
		decode_next.last = fetched.last;
		decode_next.pc = fetched.pc;
		decode_next.alu_op = alu_op;
		decode_next.operand_a = rs_value;
		decode_next.operand_b = is_rtype ? rt_value : imm_ext;
		// Variable shifts take the amount from rs
		decode_next.shamt = var_shift ? rs_value[4:0] : shamt_field;
		decode_next.dest = is_rtype ? rd_index : rt_index;
		decode_next.write = (alu_op != mips_pkg::ALU_NONE) && (decode_next.dest != '0);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			decoded.valid <= 1'b0;
		end else if (!stall) begin
			decoded <= decode_next;
		end
	end

endmodule

//--- source/fetch_stage.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module fetch_stage (
	input  logic clock,
	input  logic reset,
	input  logic run,
	input  logic stall,
	input  logic [`MIPS_COUNT_BITS-1:0] loaded_words,
	output logic read_enable,
	output mips_pkg::imem_index_t read_index,
	output mips_pkg::fetch_t fetched
);

	mips_pkg::fetch_state_e state;
	mips_pkg::word_t pc;
	mips_pkg::word_t pc_offset;
	logic last_word;

	// Byte offset from the start address to word index
	assign pc_offset = pc - `MIPS_START_ADDR;
	assign read_index = pc_offset[$bits(mips_pkg::imem_index_t)+1:2];
	assign read_enable = (state == mips_pkg::FETCH_ISSUE) && !stall;
	assign last_word = {1'b0, read_index} == loaded_words - 1'b1;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= mips_pkg::FETCH_IDLE;
			pc <= `MIPS_START_ADDR;
			fetched.valid <= 1'b0;
		end else if (state == mips_pkg::FETCH_IDLE) begin
			if (run && loaded_words != '0) begin
				state <= mips_pkg::FETCH_ISSUE;
				pc <= `MIPS_START_ADDR;
			end
			if (!stall)
				fetched.valid <= 1'b0; // bubble into decode
		end else if (!stall) begin
			fetched <= '{valid: 1'b1, last: last_word, pc: pc};
			pc <= pc + 32'd4;
			if (last_word)
				state <= mips_pkg::FETCH_IDLE;
		end
	end

endmodule

//--- source/insn_memory.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module insn_memory (
	input  logic clock,
	input  logic reset,
	input  logic load_valid,
	input  mips_pkg::word_t load_data,
	input  logic read_enable,
	input  mips_pkg::imem_index_t read_index,
	output mips_pkg::word_t read_data,
	output logic [`MIPS_COUNT_BITS-1:0] loaded_words
);

	mips_pkg::word_t mem [`MIPS_IMEM_WORDS];
	logic mem_full;

	assign mem_full = loaded_words == `MIPS_COUNT_BITS'(`MIPS_IMEM_WORDS);

	// Load count doubles as the write pointer
	always_ff @(posedge clock) begin
		if (reset) begin
			loaded_words <= '0;
		end else if (load_valid && !mem_full) begin
			loaded_words <= loaded_words + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (load_valid && !mem_full) begin
			mem[mips_pkg::imem_index_t'(loaded_words)] <= load_data;
		end
	end

	always_ff @(posedge clock) begin
		if (read_enable) begin
			read_data <= mem[read_index]; // holds otherwise
		end
	end

endmodule

//--- source/mips_core.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module mips_core (
	input  logic clock,
	input  logic reset,
	input  logic load_valid,
	input  mips_pkg::word_t load_data,
	input  logic run,
	input  logic stall,
	output logic result_valid,
	output mips_pkg::exec_result_t result,
	output logic done
);

	logic read_enable;
	mips_pkg::imem_index_t read_index;
	mips_pkg::word_t read_data;
	logic [`MIPS_COUNT_BITS-1:0] loaded_words;
	mips_pkg::fetch_t fetched;
	mips_pkg::reg_index_t rs_index;
	mips_pkg::reg_index_t rt_index;
	mips_pkg::word_t rs_value;
	mips_pkg::word_t rt_value;
	mips_pkg::decode_t decoded;
	logic wb_write;
	mips_pkg::reg_index_t wb_dest;
	mips_pkg::word_t wb_value;

	insn_memory imem (
		.clock        (clock),
		.reset        (reset),
		.load_valid   (load_valid),
		.load_data    (load_data),
		.read_enable  (read_enable),
		.read_index   (read_index),
		.read_data    (read_data),
		.loaded_words (loaded_words)
	);

	fetch_stage fetch (
		.clock        (clock),
		.reset        (reset),
		.run          (run),
		.stall        (stall),
		.loaded_words (loaded_words),
		.read_enable  (read_enable),
		.read_index   (read_index),
		.fetched      (fetched)
	);

	register_file regs (
		.clock    (clock),
		.reset    (reset),
		.rs_index (rs_index),
		.rt_index (rt_index),
		.wb_write (wb_write),
		.wb_dest  (wb_dest),
		.wb_value (wb_value),
		.rs_value (rs_value),
		.rt_value (rt_value)
	);

	decode_stage decode (
		.clock    (clock),
		.reset    (reset),
		.stall    (stall),
		.fetched  (fetched),
		.insn     (read_data),
		.rs_value (rs_value),
		.rt_value (rt_value),
		.rs_index (rs_index),
		.rt_index (rt_index),
		.decoded  (decoded)
	);

	alu_stage execute (
		.clock        (clock),
		.reset        (reset),
		.stall        (stall),
		.decoded      (decoded),
		.wb_write     (wb_write),
		.wb_dest      (wb_dest),
		.wb_value     (wb_value),
		.result_valid (result_valid),
		.result       (result),
		.done         (done)
	);

endmodule

//--- source/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Data path and address width
`define MIPS_XLEN 32

// Architectural registers
`define MIPS_REG_COUNT 32

// Instruction memory depth in words
`define MIPS_IMEM_WORDS 256

// Byte address of word 0
`define MIPS_START_ADDR 32'h8002_0000

// Loaded word count needs one bit more than the index
`define MIPS_COUNT_BITS ($clog2(`MIPS_IMEM_WORDS) + 1)

`endif

//--- source/mips_pkg.sv
`include "mips_defines.svh"

package mips_pkg;

	typedef logic [`MIPS_XLEN-1:0] word_t;
	typedef logic [$clog2(`MIPS_REG_COUNT)-1:0] reg_index_t;
	typedef logic [$clog2(`MIPS_IMEM_WORDS)-1:0] imem_index_t;

	// Primary opcodes that are executed
	typedef enum logic [5:0] {
		OP_RTYPE = 6'b000000,
		OP_ADDI  = 6'b001000,
		OP_ADDIU = 6'b001001,
		OP_SLTI  = 6'b001010,
		OP_SLTIU = 6'b001011,
		OP_ORI   = 6'b001101,
		OP_XORI  = 6'b001110,
		OP_LUI   = 6'b001111
	} opcode_e;

	typedef enum logic [5:0] {
		F_SLL  = 6'b000000,
		F_SRL  = 6'b000010,
		F_SRA  = 6'b000011,
		F_SLLV = 6'b000100,
		F_SRLV = 6'b000110,
		F_SRAV = 6'b000111,
		F_ADD  = 6'b100000,
		F_ADDU = 6'b100001,
		F_SUB  = 6'b100010,
		F_SUBU = 6'b100011,
		F_AND  = 6'b100100,
		F_OR   = 6'b100101,
		F_XOR  = 6'b100110,
		F_NOR  = 6'b100111,
		F_SLT  = 6'b101010,
		F_SLTU = 6'b101011
	} funct_e;

	typedef enum logic [3:0] {
		ALU_NONE,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI
	} alu_op_e;

	typedef enum logic {
		FETCH_IDLE,
		FETCH_ISSUE
	} fetch_state_e;

	// Word arriving from memory
	typedef struct packed {
		logic valid;
		logic last;
		word_t pc;
	} fetch_t;

	typedef struct packed {
		logic valid;
		logic last;
		word_t pc;
		alu_op_e alu_op;
		word_t operand_a;
		word_t operand_b;
		logic [4:0] shamt;
		reg_index_t dest;
		logic write;
	} decode_t;

	typedef struct packed {
		word_t pc;
		reg_index_t dest;
		logic write;
		word_t value;
	} exec_result_t;

endpackage

//--- source/register_file.sv
`timescale 1ns/100ps
`include "mips_defines.svh"

module register_file (
	input  logic clock,
	input  logic reset,
	input  mips_pkg::reg_index_t rs_index,
	input  mips_pkg::reg_index_t rt_index,
	input  logic wb_write,
	input  mips_pkg::reg_index_t wb_dest,
	input  mips_pkg::word_t wb_value,
	output mips_pkg::word_t rs_value,
	output mips_pkg::word_t rt_value
);

	mips_pkg::word_t regs [`MIPS_REG_COUNT];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `MIPS_REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wb_write && wb_dest != '0) begin
			regs[wb_dest] <= wb_value;
		end
	end

	// $zero always reads back zero
	assign rs_value = (rs_index == '0) ? '0 : regs[rs_index];
	assign rt_value = (rt_index == '0) ? '0 : regs[rt_index];

endmodule

//--- verif/mips_core_assert.sv
`timescale 1ns/100ps

module mips_core_assert (
	input logic clock,
	input logic reset,
	input logic stall,
	input logic result_valid,
	input logic done
);

	// Held item waits for stall to drop
	no_result_in_stall: assert property (@(posedge clock) disable iff (reset)
		!(result_valid && stall))
		else $error("result_valid high while stall is high");

	done_apart_from_result: assert property (@(posedge clock) disable iff (reset)
		!(done && result_valid))
		else $error("done and result_valid high in the same cycle");

	quiet_after_reset: assert property (@(posedge clock) reset |=> !result_valid)
		else $error("result_valid high in the cycle after reset");

endmodule

bind mips_core mips_core_assert checks (
	.clock        (clock),
	.reset        (reset),
	.stall        (stall),
	.result_valid (result_valid),
	.done         (done)
);

//--- verif/mips_core_golden.txt
# test <name> <stall flag, 1 = random stall>
# insn <word hex> <expected pc hex> <dest> <write> <value hex>
test alu_basic 0
insn 24010015 80020000 1 1 00000015
insn 2002fffd 80020004 2 1 fffffffd
insn 3c031234 80020008 3 1 12340000
insn 34248001 8002000c 4 1 00008015
insn 3845ff00 80020010 5 1 ffff00fd
insn 2846fffe 80020014 6 1 00000001
insn 2c27ffff 80020018 7 1 00000001
insn 00224020 8002001c 8 1 00000012
insn 00234822 80020020 9 1 edcc0015
insn 0041502a 80020024 10 1 00000001
insn 0041582b 80020028 11 1 00000000
insn 00856024 8002002c 12 1 00000015
insn 00646825 80020030 13 1 12348015
insn 00657026 80020034 14 1 edcb00fd
insn 00207827 80020038 15 1 ffffffea
insn 8c300000 8002003c 16 0 00000000
insn 00210021 80020040 0 0 0000002a
insn 00019900 80020044 19 1 00000150
insn 00018823 80020048 17 1 ffffffeb
test shift_writeback 1
insn 3c018000 80020000 1 1 80000000
insn 24020024 80020004 2 1 00000024
insn 240300f0 80020008 3 1 000000f0
insn 00012103 8002000c 4 1 f8000000
insn 00012902 80020010 5 1 08000000
insn 00033200 80020014 6 1 0000f000
insn 00433804 80020018 7 1 00000f00
insn 00414006 8002001c 8 1 08000000
insn 00444807 80020020 9 1 ff800000
insn 00855021 80020024 10 1 00000000
insn 00a15822 80020028 11 1 88000000
insn 00e96025 8002002c 12 1 ff800f00
insn 0085682a 80020030 13 1 00000001
insn 0085702b 80020034 14 1 00000000
insn 258fffff 80020038 15 1 ff800eff
insn 2cb08000 8002003c 16 1 00000001
insn 39f1ffff 80020040 17 1 ff80f100
insn 3032ffff 80020044 18 0 00000000
insn 02269824 80020048 19 1 0000f000

//--- verif/mips_core_tb.sv
`timescale 1ns/100ps

module mips_core_tb;

	localparam int CLOCK_HALF = 4;
	localparam int TEXT_BYTES = 32;

	typedef logic [8*TEXT_BYTES-1:0] text_t;

	logic clock;
	logic reset;
	logic load_valid;
	mips_pkg::word_t load_data;
	logic run;
	logic stall;
	logic result_valid;
	mips_pkg::exec_result_t result;
	logic done;

	// Golden contents of all tests back to back
	mips_pkg::word_t prog_words [$];
	mips_pkg::exec_result_t expected [$];
	string test_names [$];
	bit test_stalled [$];
	int test_first [$];
	int test_length [$];

	int value_errors;
	int other_errors;
	int watchdog_cycles;
	bit golden_ready;

	mips_core UUT (
		.clock        (clock),
		.reset        (reset),
		.load_valid   (load_valid),
		.load_data    (load_data),
		.run          (run),
		.stall        (stall),
		.result_valid (result_valid),
		.result       (result),
		.done         (done)
	);

	initial clock = 1'b0;
	always #CLOCK_HALF clock = ~clock;

	task automatic read_golden();
		int fd;
		int code;
		int last;
		int dest_num;
		int write_num;
		int stall_num;
		text_t token;
		logic [8*128-1:0] rest;
		mips_pkg::word_t word;
		mips_pkg::word_t pc_word;
		mips_pkg::word_t value_word;
		mips_pkg::exec_result_t item;
		fd = $fopen("verif/mips_core_golden.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("Cannot open the golden file verif/mips_core_golden.txt");
			return;
		end
		while ($fscanf(fd, "%s", token) == 1) begin
			if (token == text_t'("#")) begin
				code = $fgets(rest, fd); // skip comment text
			end else if (token == text_t'("test")) begin
				code = $fscanf(fd, "%s %d", token, stall_num);
				test_names.push_back($sformatf("%0s", token));
				test_stalled.push_back(stall_num != 0);
				test_first.push_back(prog_words.size());
				test_length.push_back(0);
			end else if (token == text_t'("insn") && test_length.size() > 0) begin
				code = $fscanf(fd, "%h %h %d %d %h", word, pc_word, dest_num, write_num,
					value_word);
				item.pc = pc_word;
				item.dest = mips_pkg::reg_index_t'(dest_num);
				item.write = write_num != 0;
				item.value = value_word;
				prog_words.push_back(word);
				expected.push_back(item);
				last = test_length.size() - 1;
				test_length[last] = test_length[last] + 1;
			end else begin
				other_errors++;
				$display("Unexpected entry in the golden file: %0s", token);
			end
		end
		$fclose(fd);
	endtask

	task automatic check_result(input string name, input int index,
			input mips_pkg::exec_result_t exp, input mips_pkg::exec_result_t act);
		if (act.pc !== exp.pc) begin
			value_errors++;
			$display("Mismatch %s result %0d pc: expected %h actual %h",
				name, index, exp.pc, act.pc);
		end
		if (act.dest !== exp.dest) begin
			value_errors++;
			$display("Mismatch %s result %0d dest: expected %0d actual %0d",
				name, index, exp.dest, act.dest);
		end
		if (act.write !== exp.write) begin
			value_errors++;
			$display("Mismatch %s result %0d write: expected %b actual %b",
				name, index, exp.write, act.write);
		end
		if (act.value !== exp.value) begin
			value_errors++;
			$display("Mismatch %s result %0d value: expected %h actual %h",
				name, index, exp.value, act.value);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			value_errors++;
			$display("Mismatch %s result count: expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic reset_dut();
		@(negedge clock);
		reset = 1'b1;
		stall = 1'b0;
		run = 1'b0;
		load_valid = 1'b0;
		repeat (3) @(negedge clock);
		reset = 1'b0;
	endtask

	task automatic load_program(input int first, input int length);
		for (int i = 0; i < length; i++) begin
			@(negedge clock);
			load_valid = 1'b1;
			load_data = prog_words[first + i];
		end
		@(negedge clock);
		load_valid = 1'b0;
	endtask

	task automatic run_test(input int t);
		string name;
		int seen;
		int cycles;
		int limit;
		bit finished;
		name = test_names[t];
		limit = test_length[t] * 16 + 20;
		reset_dut();
		load_program(test_first[t], test_length[t]);
		@(negedge clock);
		run = 1'b1;
		@(negedge clock);
		run = 1'b0;
		seen = 0;
		cycles = 0;
		finished = 1'b0;
		while (!finished && cycles < limit) begin
			stall = test_stalled[t] && ($urandom() % 2 == 1);
			#2; // let outputs follow the new stall level
			if (result_valid) begin
				if (stall) begin
					other_errors++;
					$display("%s: result while stalled", name);
				end
				if (seen < test_length[t]) begin
					check_result(name, seen, expected[test_first[t] + seen], result);
				end else begin
					other_errors++;
					$display("%s: more results than program words", name);
				end
				seen++;
			end
			if (done) begin
				if (seen < test_length[t] || result_valid) begin
					other_errors++;
					$display("%s: done rose before the last result", name);
				end
				finished = 1'b1;
			end
			cycles++;
			@(negedge clock);
		end
		stall = 1'b0;
		if (!finished) begin
			other_errors++;
			$display("%s: done never rose", name);
		end
		check_count(name, test_length[t], seen);
	endtask

	initial begin
		reset = 1'b1;
		load_valid = 1'b0;
		load_data = '0;
		run = 1'b0;
		stall = 1'b0;
		value_errors = 0;
		other_errors = 0;
		golden_ready = 1'b0;
		void'($urandom(80433));
		read_golden();
		watchdog_cycles = prog_words.size() * 20 + 200;
		golden_ready = 1'b1;
		if (test_names.size() == 0) begin
			other_errors++;
			$display("No tests found in the golden file");
		end
		for (int t = 0; t < test_names.size(); t++)
			run_test(t);
		$display("Errors: %0d mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors + other_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// Backstop in case the pipeline locks up
	initial begin
		wait (golden_ready);
		repeat (watchdog_cycles) @(posedge clock);
		$display("Timeout: run exceeded %0d cycles", watchdog_cycles);
		$display("** FAIL **");
		$finish;
	end

endmodule
